// File: tb.f
src/sdram_front_pkg.sv
src/beat_counter.sv
src/read_line_cache.sv
src/stream_write_buffer.sv
src/burst_arbiter.sv
src/sdram_front.sv
sim/burst_mem_model.sv
sim/tb_sdram_front.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_sdram_front -f tb.f

output=$(./obj_dir/Vtb_sdram_front 2>&1 || true)
echo "$output"

if echo "$output" | grep -qxF "Simulation finished: PASS"; then
    exit 0
else
    exit 1
fi

// File: sim/tb_sdram_front.sv
`timescale 1ns/1ps

module tb_sdram_front;
    import sdram_front_pkg::*;

    localparam int wait_limit = 300;                 // cycles per wait

    logic              clk;
    logic              sys_rst_n;
    logic [addr_w-1:0] address;
    logic [data_w-1:0] data_in;
    logic [data_w-1:0] data_out;
    logic              read_req;
    logic              read_ack;
    logic              write_req;
    logic              write_ack;
    logic              write_latch_address;
    logic              write_en;
    logic [addr_w-1:0] write_address;
    mem_cmd_t          mem_cmd;
    logic [data_w-1:0] mem_wdata;
    mem_rsp_t          mem_rsp;
    integer            seed;
    logic [addr_w-1:0] line_addr;
    logic [data_w-1:0] line_word;
    logic [data_w-1:0] stream_words [2*block_words];

    sdram_front dut (
        .clk                 (clk),
        .sys_rst_n           (sys_rst_n),
        .address             (address),
        .data_in             (data_in),
        .data_out            (data_out),
        .read_req            (read_req),
        .read_ack            (read_ack),
        .write_req           (write_req),
        .write_ack           (write_ack),
        .write_latch_address (write_latch_address),
        .write_en            (write_en),
        .write_address       (write_address),
        .mem_cmd             (mem_cmd),
        .mem_wdata           (mem_wdata),
        .mem_rsp             (mem_rsp)
    );

    burst_mem_model u_mem (
        .clk       (clk),
        .sys_rst_n (sys_rst_n),
        .mem_cmd   (mem_cmd),
        .mem_wdata (mem_wdata),
        .mem_rsp   (mem_rsp)
    );

    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string test, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else stop_with_failure($sformatf(
            "Mismatch in %s: expected 0x%0h, actual 0x%0h", test, expected, actual));
    endtask

    // inputs change 2 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic wait_read_ack(input string test);
        int n;
        n = 0;
        while (!read_ack && n < wait_limit) begin
            next_cycle();
            n++;
        end
        assert (read_ack) else stop_with_failure({"timed out waiting for read_ack in ", test});
    endtask

    task automatic wait_stored_bursts(input string test, input int target);
        int n;
        n = 0;
        while (u_mem.wr_bursts < target && n < wait_limit) begin
            next_cycle();
            n++;
        end
        assert (u_mem.wr_bursts >= target)
            else stop_with_failure({"write burst never reached memory in ", test});
    endtask

    task automatic single_write(input string test, input logic [addr_w-1:0] addr,
                                input logic [data_w-1:0] word);
        int n;
        address   = addr;
        data_in   = word;
        write_req = 1'b1;
        n         = 0;
        next_cycle();
        while (!write_ack && n < wait_limit) begin
            next_cycle();
            n++;
        end
        assert (write_ack) else stop_with_failure({"timed out waiting for write_ack in ", test});
        write_req = 1'b0;
        next_cycle();
    endtask

    // read_req is already high here
    task automatic finish_read(input string test, output logic [data_w-1:0] word);
        wait_read_ack(test);
        word     = data_out;
        read_req = 1'b0;
        next_cycle();
        check_value({test, " ack release"}, 0, read_ack);
        check_value({test, " data release"}, 0, data_out);
    endtask

    task automatic read_word(input string test, input logic [addr_w-1:0] addr,
                             output logic [data_w-1:0] word);
        address  = addr;
        read_req = 1'b1;
        finish_read(test, word);
    endtask

    task automatic stream_block(input logic latch_start, input logic [addr_w-1:0] start,
                                input int first, input logic read_at_end,
                                input logic [addr_w-1:0] read_addr);
        for (int i = 0; i < block_words; i++) begin
            stream_words[first+i] = data_w'(next_random());
            write_en              = 1'b1;
            write_latch_address   = latch_start && (i == 0);
            address               = start;
            data_in               = stream_words[first+i];
            if (read_at_end && i == block_words - 1) begin
                address  = read_addr;                // read rises with the last word
                read_req = 1'b1;
            end
            next_cycle();
        end
        write_en            = 1'b0;
        write_latch_address = 1'b0;
    endtask

    task automatic check_reset_state();
        check_value("reset read_ack", 0, read_ack);
        check_value("reset write_ack", 0, write_ack);
        check_value("reset rd_req", 0, mem_cmd.rd_req);
        check_value("reset wr_req", 0, mem_cmd.wr_req);
        check_value("reset write_address", 0, write_address);
    endtask

    task automatic write_then_miss();
        logic [data_w-1:0] got;
        int                base_w;
        int                base_r;
        int                base_b;
        line_addr = addr_w'(next_random());
        line_word = data_w'(next_random());
        base_w    = u_mem.wr_bursts;
        single_write("single write", line_addr, line_word);
        wait_stored_bursts("single write", base_w + 1);
        check_value("single write stored", line_word, u_mem.peek(line_addr));
        base_r = u_mem.rd_bursts;
        base_b = u_mem.rd_beats;
        read_word("read miss", line_addr, got);
        check_value("read miss data", line_word, got);
        check_value("read miss bursts", base_r + 1, u_mem.rd_bursts);
        check_value("read miss beats", base_b + line_words, u_mem.rd_beats);
    endtask

    task automatic read_hit();
        logic [addr_w-1:0] hit_addr;
        hit_addr = {line_addr[23:2], line_addr[1:0] + 2'd1};
        address  = hit_addr;
        read_req = 1'b1;
        next_cycle();
        check_value("read hit ack", 1, read_ack);
        check_value("read hit data", u_mem.peek(hit_addr), data_out);
        read_req = 1'b0;
        next_cycle();
        check_value("read hit release", 0, read_ack);
        check_value("read hit fill request", 0, mem_cmd.rd_req);   // no burst started
    endtask

    task automatic invalidate_line();
        logic [data_w-1:0] new_word;
        logic [data_w-1:0] got;
        int                base_w;
        int                base_r;
        new_word = ~line_word;
        base_w   = u_mem.wr_bursts;
        base_r   = u_mem.rd_bursts;
        single_write("invalidate write", line_addr, new_word);
        wait_stored_bursts("invalidate write", base_w + 1);
        read_word("invalidate read", line_addr, got);
        check_value("invalidate data", new_word, got);
        check_value("invalidate bursts", base_r + 1, u_mem.rd_bursts);
    endtask

    task automatic stream_two_blocks();
        logic [addr_w-1:0] start;
        int                base_w;
        int                base_b;
        start  = addr_w'(next_random()) & 24'hffff00;
        base_w = u_mem.wr_bursts;
        base_b = u_mem.wr_beats;
        stream_block(1'b1, start, 0, 1'b0, '0);
        wait_stored_bursts("streaming", base_w + 1);
        stream_block(1'b0, start, block_words, 1'b0, '0);
        wait_stored_bursts("streaming", base_w + 2);
        check_value("streaming address", start + 24'd32, write_address);
        check_value("streaming bursts", base_w + 2, u_mem.wr_bursts);
        check_value("streaming beats", base_b + 32, u_mem.wr_beats);
        for (int i = 0; i < 2 * block_words; i++) begin
            check_value("streaming data", stream_words[i], u_mem.peek(start + addr_w'(i)));
        end
    endtask

    task automatic flush_behind_read();
        logic [addr_w-1:0] start;
        logic [addr_w-1:0] rd_addr;
        logic [data_w-1:0] exp_rd;
        logic [data_w-1:0] got;
        int                base_w;
        int                base_r;
        start   = addr_w'(next_random()) & 24'hffff00;
        rd_addr = start + 24'h40;                    // outside the streamed block
        exp_rd  = u_mem.peek(rd_addr);
        base_w  = u_mem.wr_bursts;
        base_r  = u_mem.rd_bursts;
        stream_block(1'b1, start, 0, 1'b1, rd_addr);
        finish_read("mixed read", got);
        check_value("mixed read data", exp_rd, got);
        check_value("mixed read bursts", base_r + 1, u_mem.rd_bursts);
        check_value("mixed flush order", base_w, u_mem.wr_bursts);   // fill went first
        wait_stored_bursts("mixed flush", base_w + 1);
        for (int i = 0; i < block_words; i++) begin
            check_value("mixed flush data", stream_words[i], u_mem.peek(start + addr_w'(i)));
        end
    endtask

    initial begin
        seed                = 97644;
        sys_rst_n           = 1'b0;
        address             = '0;
        data_in             = '0;
        read_req            = 1'b0;
        write_req           = 1'b0;
        write_latch_address = 1'b0;
        write_en            = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        sys_rst_n = 1'b1;
        check_reset_state();
        next_cycle();
        write_then_miss();
        read_hit();
        invalidate_line();
        stream_two_blocks();
        flush_behind_read();
        repeat (4) next_cycle();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: sim/burst_mem_model.sv
`timescale 1ns/1ps

module burst_mem_model (
    input  logic                               clk,
    input  logic                               sys_rst_n,
    input  sdram_front_pkg::mem_cmd_t          mem_cmd,
    input  logic [sdram_front_pkg::data_w-1:0] mem_wdata,
    output sdram_front_pkg::mem_rsp_t          mem_rsp
);
    import sdram_front_pkg::*;

    logic [data_w-1:0]  words [logic [addr_w-1:0]];   // only written words are kept
    integer             seed;
    logic               busy;
    logic               cool;                       // old request still visible
    logic               is_read;
    logic [addr_w-1:0]  next_addr;
    logic [burst_w-1:0] left;
    logic [1:0]         gap;                        // idle cycles before next ack
    logic [addr_w-1:0]  ack_addr;
    logic               ack_last;
    logic               cap_pend;
    logic [addr_w-1:0]  cap_addr;
    logic               cap_last;
    int                 rd_bursts;
    int                 wr_bursts;
    int                 rd_beats;
    int                 wr_beats;

    // unwritten words read back a pattern of their own address
    function automatic logic [data_w-1:0] peek(input logic [addr_w-1:0] a);
        if (words.exists(a)) begin
            return words[a];
        end
        return a[15:0] ^ {a[7:0], a[23:16]};
    endfunction

    initial begin
        seed = 97644;
    end

    always @(posedge clk or negedge sys_rst_n) begin : port_seq
        int r;
        if (!sys_rst_n) begin
            mem_rsp   <= '0;
            busy      <= 1'b0;
            cool      <= 1'b0;
            is_read   <= 1'b0;
            next_addr <= '0;
            left      <= '0;
            gap       <= '0;
            ack_addr  <= '0;
            ack_last  <= 1'b0;
            cap_pend  <= 1'b0;
            cap_addr  <= '0;
            cap_last  <= 1'b0;
            rd_bursts <= 0;
            wr_bursts <= 0;
            rd_beats  <= 0;
            wr_beats  <= 0;
        end else begin
            r = $random(seed);
            mem_rsp.rd_ack <= 1'b0;
            mem_rsp.wr_ack <= 1'b0;
            cap_pend       <= mem_rsp.wr_ack;       // word arrives a cycle after its ack
            cap_addr       <= ack_addr;
            cap_last       <= ack_last;
            cool           <= 1'b0;
            if (cap_pend) begin
                words[cap_addr] = mem_wdata;
                wr_beats <= wr_beats + 1;
                if (cap_last) begin
                    wr_bursts <= wr_bursts + 1;
                end
            end
            if (!busy) begin
                if ((mem_cmd.rd_req || mem_cmd.wr_req) && !cool) begin
                    busy      <= 1'b1;
                    is_read   <= mem_cmd.rd_req;
                    next_addr <= mem_cmd.addr;
                    left      <= mem_cmd.burst_len;
                    gap       <= 2'($unsigned(r) % 3);
                end
            end else if (gap != 2'd0) begin
                gap <= gap - 2'd1;
            end else begin
                if (is_read) begin
                    mem_rsp.rd_ack <= 1'b1;
                    mem_rsp.rdata  <= peek(next_addr);
                    rd_beats       <= rd_beats + 1;
                    if (left == burst_w'(1)) begin
                        rd_bursts <= rd_bursts + 1;
                    end
                end else begin
                    mem_rsp.wr_ack <= 1'b1;
                end
                ack_addr  <= next_addr;
                ack_last  <= (left == burst_w'(1));
                next_addr <= next_addr + addr_w'(1);
                left      <= left - burst_w'(1);
                gap       <= 2'($unsigned(r) % 3);
                if (left == burst_w'(1)) begin
                    busy <= 1'b0;                   // last beat of the burst
                    cool <= 1'b1;
                end
            end
        end
    end

endmodule

// File: src/sdram_front.sv
`timescale 1ns/1ps

module sdram_front (
    input  logic                               clk,
    input  logic                               sys_rst_n,
    input  logic [sdram_front_pkg::addr_w-1:0] address,
    input  logic [sdram_front_pkg::data_w-1:0] data_in,
    output logic [sdram_front_pkg::data_w-1:0] data_out,
    input  logic                               read_req,
    output logic                               read_ack,
    input  logic                               write_req,
    output logic                               write_ack,
    input  logic                               write_latch_address,
    input  logic                               write_en,
    output logic [sdram_front_pkg::addr_w-1:0] write_address,
    output sdram_front_pkg::mem_cmd_t          mem_cmd,
    output logic [sdram_front_pkg::data_w-1:0] mem_wdata,
    input  sdram_front_pkg::mem_rsp_t          mem_rsp
);
    import sdram_front_pkg::*;

    logic                         fill_req;
    addr_u                        fill_addr;
    fill_beat_t                   fill_beat;
    logic                         fill_done;
    logic                         flush_req;
    addr_u                        flush_addr;
    logic [$clog2(block_words)-1:0] flush_index;
    logic [data_w-1:0]            flush_word;
    logic                         flush_done;
    logic                         beat_clear;
    logic                         beat_step;
    logic [burst_w-1:0]           beat_len;
    logic [burst_w-1:0]           beat_idx;
    logic                         beat_last;

    read_line_cache u_cache (
        .clk       (clk),
        .sys_rst_n (sys_rst_n),
        .address   (address),
        .read_req  (read_req),
        .write_req (write_req),
        .write_en  (write_en),
        .read_ack  (read_ack),
        .data_out  (data_out),
        .fill_req  (fill_req),
        .fill_addr (fill_addr),
        .fill_beat (fill_beat),
        .fill_done (fill_done)
    );

    stream_write_buffer u_stream (
        .clk                 (clk),
        .sys_rst_n           (sys_rst_n),
        .address             (address),
        .data_in             (data_in),
        .write_en            (write_en),
        .write_latch_address (write_latch_address),
        .write_address       (write_address),
        .flush_req           (flush_req),
        .flush_addr          (flush_addr),
        .flush_index         (flush_index),
        .flush_word          (flush_word),
        .flush_done          (flush_done)
    );

    burst_arbiter u_arb (
        .clk         (clk),
        .sys_rst_n   (sys_rst_n),
        .address     (address),
        .data_in     (data_in),
        .write_req   (write_req),
        .write_ack   (write_ack),
        .fill_req    (fill_req),
        .fill_addr   (fill_addr),
        .fill_beat   (fill_beat),
        .fill_done   (fill_done),
        .flush_req   (flush_req),
        .flush_addr  (flush_addr),
        .flush_index (flush_index),
        .flush_word  (flush_word),
        .flush_done  (flush_done),
        .mem_cmd     (mem_cmd),
        .mem_wdata   (mem_wdata),
        .mem_rsp     (mem_rsp),
        .beat_clear  (beat_clear),
        .beat_step   (beat_step),
        .beat_len    (beat_len),
        .beat_idx    (beat_idx),
        .beat_last   (beat_last)
    );

    beat_counter u_beats (
        .clk        (clk),
        .sys_rst_n  (sys_rst_n),
        .beat_clear (beat_clear),
        .beat_step  (beat_step),
        .beat_len   (beat_len),
        .beat_idx   (beat_idx),
        .beat_last  (beat_last)
    );

endmodule

// File: src/burst_arbiter.sv
`timescale 1ns/1ps

module burst_arbiter (
    input  logic                                clk,
    input  logic                                sys_rst_n,
    input  logic [sdram_front_pkg::addr_w-1:0]  address,
    input  logic [sdram_front_pkg::data_w-1:0]  data_in,
    input  logic                                write_req,
    output logic                                write_ack,
    input  logic                                fill_req,
    input  sdram_front_pkg::addr_u              fill_addr,
    output sdram_front_pkg::fill_beat_t         fill_beat,
    output logic                                fill_done,
    input  logic                                flush_req,
    input  sdram_front_pkg::addr_u              flush_addr,
    output logic [$clog2(sdram_front_pkg::block_words)-1:0] flush_index,
    input  logic [sdram_front_pkg::data_w-1:0]  flush_word,
    output logic                                flush_done,
    output sdram_front_pkg::mem_cmd_t           mem_cmd,
    output logic [sdram_front_pkg::data_w-1:0]  mem_wdata,
    input  sdram_front_pkg::mem_rsp_t           mem_rsp,
    output logic                                beat_clear,
    output logic                                beat_step,
    output logic [sdram_front_pkg::burst_w-1:0] beat_len,
    input  logic [sdram_front_pkg::burst_w-1:0] beat_idx,
    input  logic                                beat_last
);
    import sdram_front_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_fill,
        st_single,
        st_block,
        st_finish
    } state_t;

    state_t state;
    logic   write_req_d;
    logic   write_pend;                            // single write waiting

    assign beat_clear  = (state == st_idle);
    assign beat_len    = mem_cmd.burst_len;
    assign flush_index = beat_idx[$clog2(block_words)-1:0];

    always_comb begin
        case (state)
            st_fill:            beat_step = mem_rsp.rd_ack;
            st_single, st_block: beat_step = mem_rsp.wr_ack;
            default:            beat_step = 1'b0;
        endcase
    end

    // read data goes straight to the cache
    always_comb begin
        fill_beat.valid = (state == st_fill) && mem_rsp.rd_ack;
        fill_beat.index = beat_idx[$clog2(line_words)-1:0];
        fill_beat.data  = mem_rsp.rdata;
    end

    // word k is presented the cycle after ack k
    always_ff @(posedge clk) begin
        if (state == st_single && mem_rsp.wr_ack) begin
            mem_wdata <= data_in;
        end else if (state == st_block && mem_rsp.wr_ack) begin
            mem_wdata <= flush_word;
        end
    end

    always_ff @(posedge clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state       <= st_idle;
            mem_cmd     <= '0;
            fill_done   <= 1'b0;
            write_ack   <= 1'b0;
            flush_done  <= 1'b0;
            write_req_d <= 1'b0;
            write_pend  <= 1'b0;
        end else begin
            write_req_d <= write_req;
            fill_done   <= 1'b0;
            write_ack   <= 1'b0;
            flush_done  <= 1'b0;
            if (write_req && !write_req_d) begin
                write_pend <= 1'b1;
            end else if (write_ack) begin
                write_pend <= 1'b0;
            end
            case (state)
                st_idle: begin
                    if (fill_req) begin                  // reads first
                        mem_cmd.rd_req    <= 1'b1;
                        mem_cmd.addr      <= fill_addr;
                        mem_cmd.burst_len <= burst_w'(line_words);
                        state             <= st_fill;
                    end else if (write_pend) begin
                        mem_cmd.wr_req    <= 1'b1;
                        mem_cmd.addr      <= address;
                        mem_cmd.burst_len <= burst_w'(1);
                        state             <= st_single;
                    end else if (flush_req) begin
                        mem_cmd.wr_req    <= 1'b1;
                        mem_cmd.addr      <= flush_addr;
                        mem_cmd.burst_len <= burst_w'(block_words);
                        state             <= st_block;
                    end
                end
                st_fill: begin
                    if (beat_last) begin
                        mem_cmd.rd_req <= 1'b0;
                        fill_done      <= 1'b1;
                        state          <= st_finish;
                    end
                end
                st_single: begin
                    if (beat_last) begin
                        mem_cmd.wr_req <= 1'b0;
                        write_ack      <= 1'b1;
                        state          <= st_finish;
                    end
                end
                st_block: begin
                    if (beat_last) begin
                        mem_cmd.wr_req <= 1'b0;
                        flush_done     <= 1'b1;
                        state          <= st_finish;
                    end
                end
                st_finish: state <= st_idle;             // requester drops here
                default:   state <= st_idle;
            endcase
        end
    end

endmodule

// File: src/stream_write_buffer.sv
`timescale 1ns/1ps

module stream_write_buffer (
    input  logic                                     clk,
    input  logic                                     sys_rst_n,
    input  logic [sdram_front_pkg::addr_w-1:0]       address,
    input  logic [sdram_front_pkg::data_w-1:0]       data_in,
    input  logic                                     write_en,
    input  logic                                     write_latch_address,
    output logic [sdram_front_pkg::addr_w-1:0]       write_address,
    output logic                                     flush_req,
    output sdram_front_pkg::addr_u                   flush_addr,
    input  logic [$clog2(sdram_front_pkg::block_words)-1:0] flush_index,
    output logic [sdram_front_pkg::data_w-1:0]       flush_word,
    input  logic                                     flush_done
);
    import sdram_front_pkg::*;

    localparam int off_w = $clog2(block_words);

    logic [data_w-1:0] front_buf [block_words];
    logic [data_w-1:0] back_buf  [block_words];
    logic [addr_w-1:0] wr_ptr;
    addr_u             cur_addr;
    logic              block_end;

    // latch overrides the running pointer
    assign cur_addr      = write_latch_address ? address : wr_ptr;
    assign block_end     = write_en && (cur_addr.block_view.offset == off_w'(block_words - 1));
    assign write_address = wr_ptr;
    assign flush_word    = back_buf[flush_index];

    always_ff @(posedge clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            wr_ptr <= '0;
        end else if (write_en) begin
            wr_ptr <= cur_addr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (write_en) begin
            front_buf[cur_addr.block_view.offset] <= data_in;
        end
        if (block_end) begin
            // last word goes straight to the back buffer
            for (int i = 0; i < block_words - 1; i++) begin
                back_buf[i] <= front_buf[i];
            end
            back_buf[block_words-1] <= data_in;
            flush_addr.block_view.block  <= cur_addr.block_view.block;
            flush_addr.block_view.offset <= '0;
        end
    end

    always_ff @(posedge clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            flush_req <= 1'b0;
        end else if (block_end) begin
            flush_req <= 1'b1;
        end else if (flush_done) begin
            flush_req <= 1'b0;                   // block written out
        end
    end

endmodule

// File: src/read_line_cache.sv
`timescale 1ns/1ps

module read_line_cache (
    input  logic                               clk,
    input  logic                               sys_rst_n,
    input  sdram_front_pkg::addr_u             address,
    input  logic                               read_req,
    input  logic                               write_req,
    input  logic                               write_en,
    output logic                               read_ack,
    output logic [sdram_front_pkg::data_w-1:0] data_out,
    output logic                               fill_req,
    output sdram_front_pkg::addr_u             fill_addr,
    input  sdram_front_pkg::fill_beat_t        fill_beat,
    input  logic                               fill_done
);
    import sdram_front_pkg::*;

    logic [data_w-1:0] line_buf [line_words];
    logic [21:0]       line_tag;
    logic              line_valid;
    logic              read_req_d;
    logic              read_rise;
    logic              hit;

    assign read_rise = read_req && !read_req_d;
    assign hit       = line_valid && (line_tag == address.line_view.tag);

    // fill beats land by word index
    always_ff @(posedge clk) begin
        if (fill_beat.valid) begin
            line_buf[fill_beat.index] <= fill_beat.data;
        end
    end

    always_ff @(posedge clk) begin
        if (read_rise && !hit) begin
            fill_addr.line_view.tag   <= address.line_view.tag;
            fill_addr.line_view.index <= 2'b00;       // line aligned
        end
        if (fill_done) begin
            line_tag <= fill_addr.line_view.tag;
        end
    end

    always_ff @(posedge clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            read_req_d <= 1'b0;
            read_ack   <= 1'b0;
            data_out   <= '0;
            fill_req   <= 1'b0;
            line_valid <= 1'b0;
        end else begin
            read_req_d <= read_req;
            if (read_rise) begin
                if (hit) begin
                    read_ack <= 1'b1;                // answered from the line
                    data_out <= line_buf[address.line_view.index];
                end else begin
                    fill_req   <= 1'b1;
                    line_valid <= 1'b0;
                end
            end else if (fill_done) begin
                fill_req   <= 1'b0;
                line_valid <= 1'b1;
                read_ack   <= 1'b1;
                data_out   <= line_buf[address.line_view.index];
            end else if (!read_req) begin
                read_ack <= 1'b0;
                data_out <= '0;
            end
            // any write may touch the cached line
            if (write_req || write_en) begin
                line_valid <= 1'b0;
            end
        end
    end

endmodule

// File: src/beat_counter.sv
`timescale 1ns/1ps

module beat_counter (
    input  logic                                clk,
    input  logic                                sys_rst_n,
    input  logic                                beat_clear,
    input  logic                                beat_step,
    input  logic [sdram_front_pkg::burst_w-1:0] beat_len,
    output logic [sdram_front_pkg::burst_w-1:0] beat_idx,
    output logic                                beat_last
);
    import sdram_front_pkg::*;

    always_ff @(posedge clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            beat_idx <= '0;
        end else if (beat_clear) begin
            beat_idx <= '0;                      // restart for next burst
        end else if (beat_step) begin
            beat_idx <= beat_idx + burst_w'(1);
        end
    end

    // high in the cycle of the final ack
    assign beat_last = beat_step && (beat_idx == beat_len - burst_w'(1));

endmodule

// File: src/sdram_front_pkg.sv
package sdram_front_pkg;

    localparam int addr_w      = 24;
    localparam int data_w      = 16;
    localparam int line_words  = 4;
    localparam int block_words = 16;
    localparam int burst_w     = 5;

    typedef struct packed {
        logic [21:0] tag;                  // line number
        logic [1:0]  index;                // word within line
    } line_view_t;

    typedef struct packed {
        logic [19:0] block;                // block number
        logic [3:0]  offset;               // word within block
    } block_view_t;

    // one address word, seen as a cache line or as a stream block
    typedef union packed {
        line_view_t  line_view;
        block_view_t block_view;
    } addr_u;

    typedef struct packed {
        logic               rd_req;
        logic               wr_req;
        logic [addr_w-1:0]  addr;
        logic [burst_w-1:0] burst_len;
    } mem_cmd_t;

    typedef struct packed {
        logic              rd_ack;
        logic              wr_ack;
        logic [data_w-1:0] rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic              valid;
        logic [1:0]        index;
        logic [data_w-1:0] data;
    } fill_beat_t;

endpackage
